// ==== Bender.yml ====
package:
  name: lsu

sources:
  # design
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_wait_timer.sv
      - hdl/lsu_store_align.sv
      - hdl/lsu_load_align.sv
      - hdl/lsu_data_sram.sv
      - hdl/lsu_ctrl_fsm.sv
      - hdl/lsu_top.sv

  # verification
  - target: test
    files:
      - tests/lsu_props.sv
      - tests/lsu_tb.sv

// ==== hdl/lsu_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm (
    input  wire logic             clock,
    input  wire logic             arst_n,
    input  wire logic             req_valid,
    input  wire lsu_pkg::lsu_req_t req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    input  wire logic             rsp_ready,
    output logic                  timer_start,
    input  wire logic             timer_done,
    output lsu_pkg::lsu_req_t     held_req,
    input  wire logic [31:0]      st_wdata,
    input  wire logic [3:0]       st_wmask,
    output lsu_pkg::mem_cmd_t     mem_cmd
);

    lsu_pkg::lsu_state_e state;
    lsu_pkg::lsu_state_e state_nxt;
    logic accept;
    logic in_access;
    logic is_store;

    // one request in flight, so only idle takes a new one
    assign req_ready = (state == lsu_pkg::ST_IDLE);
    assign accept    = req_valid && req_ready;

    // timer loads on the same edge that accepts
    assign timer_start = accept;

    assign rsp_valid = (state == lsu_pkg::ST_RESP);
    assign in_access = (state == lsu_pkg::ST_ACCESS);

    // sw and sb write, everything else reads
    assign is_store = (held_req.op == lsu_pkg::OP_SW) || (held_req.op == lsu_pkg::OP_SB);

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::ST_IDLE: begin
                if (accept) begin
                    state_nxt = lsu_pkg::ST_WAIT;
                end
            end
            lsu_pkg::ST_WAIT: begin
                // stay until the wait states run out
                if (timer_done) begin
                    state_nxt = lsu_pkg::ST_ACCESS;
                end
            end
            lsu_pkg::ST_ACCESS: begin
                // single access cycle, sram acts on the leaving edge
                state_nxt = lsu_pkg::ST_RESP;
            end
            lsu_pkg::ST_RESP: begin
                // hold the response under back-pressure
                if (rsp_ready) begin
                    state_nxt = lsu_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = lsu_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= lsu_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request copy kept until the next accept
    always_ff @(posedge clock) begin
        if (accept) begin
            held_req <= req;
        end
    end

    // memory command, live only in the access cycle
    always_comb begin
        mem_cmd.en    = in_access;
        mem_cmd.we    = in_access && is_store;
        // word index, low address bits dropped
        mem_cmd.index = held_req.addr[lsu_pkg::MEM_IDX_W+1:2];
        mem_cmd.wdata = st_wdata;
        // no lanes outside a write
        mem_cmd.wmask = mem_cmd.we ? st_wmask : 4'b0000;
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_data_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_data_sram (
    input  wire logic              clock,
    input  wire lsu_pkg::mem_cmd_t mem_cmd,
    output logic [31:0]            rdata
);

    // word array, byte lanes written separately
    logic [31:0] mem [lsu_pkg::MEM_WORDS];
    logic [31:0] rdata_q;

    assign rdata = rdata_q;

    // write on enabled stores, masked per byte
    always_ff @(posedge clock) begin
        if (mem_cmd.en && mem_cmd.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_cmd.wmask[b]) begin
                    mem[mem_cmd.index][b*8 +: 8] <= mem_cmd.wdata[b*8 +: 8];
                end
            end
        end
    end

    // read register
    // loads only, keeps the last word between accesses
    always_ff @(posedge clock) begin
        if (mem_cmd.en && !mem_cmd.we) begin
            rdata_q <= mem[mem_cmd.index];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  wire lsu_pkg::lsu_op_e op,
    input  wire logic [1:0]       offset,
    input  wire logic [31:0]      mem_word,
    output logic [31:0]           rdata
);

    logic [7:0] lane;

    // byte picked by the address offset
    always_comb begin
        case (offset)
            2'd0: lane = mem_word[7:0];
            2'd1: lane = mem_word[15:8];
            2'd2: lane = mem_word[23:16];
            default: lane = mem_word[31:24];
        endcase
    end

    always_comb begin
        case (op)
            lsu_pkg::OP_LW: rdata = mem_word;
            // zero extended, no sign
            lsu_pkg::OP_LBU: rdata = {24'h0, lane};
            // stores answer with zero
            default: rdata = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // data memory geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = 8;

    // wait states before each memory access
    localparam int MEM_LATENCY = 2;
    localparam int LAT_W = 2;

    // supported memory operations
    typedef enum logic [1:0] {
        OP_LW  = 2'd0,
        OP_LBU = 2'd1,
        OP_SW  = 2'd2,
        OP_SB  = 2'd3
    } lsu_op_e;

    // controller phases
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_WAIT   = 2'd1,
        ST_ACCESS = 2'd2,
        ST_RESP   = 2'd3
    } lsu_state_e;

    // request channel payload, byte address
    // sb only uses wdata byte 0
    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    // response payload, zero for stores
    typedef struct packed {
        logic [31:0] rdata;
    } lsu_rsp_t;

    // one sram access, word indexed
    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [MEM_IDX_W-1:0] index;
        logic [31:0]          wdata;
        logic [3:0]           wmask;
    } mem_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
    input  wire lsu_pkg::lsu_op_e op,
    input  wire logic [1:0]       offset,
    input  wire logic [31:0]      wdata,
    output logic [31:0]           st_wdata,
    output logic [3:0]            st_wmask
);

    logic [7:0] wbyte;

    // sb stores the low byte only
    assign wbyte = wdata[7:0];

    always_comb begin
        st_wdata = 32'h0;
        st_wmask = 4'b0000;
        case (op)
            lsu_pkg::OP_SW: begin
                // whole word, offset ignored
                st_wdata = wdata;
                st_wmask = 4'b1111;
            end
            lsu_pkg::OP_SB: begin
                // byte moved into its lane, one-hot mask
                case (offset)
                    2'd0: st_wdata = {24'h0, wbyte};
                    2'd1: st_wdata = {16'h0, wbyte, 8'h0};
                    2'd2: st_wdata = {8'h0, wbyte, 16'h0};
                    default: st_wdata = {wbyte, 24'h0};
                endcase
                st_wmask = 4'b0001 << offset;
            end
            default: begin
                // loads write nothing
                st_wdata = 32'h0;
                st_wmask = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire logic              clock,
    input  wire logic              arst_n,
    input  wire logic              req_valid,
    input  wire lsu_pkg::lsu_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output lsu_pkg::lsu_rsp_t      rsp,
    input  wire logic              rsp_ready
);

    // controller to timer
    logic timer_start;
    logic timer_done;

    // latched request feeding both aligners
    lsu_pkg::lsu_req_t held_req;

    // store path
    logic [31:0] st_wdata;
    logic [3:0]  st_wmask;
    lsu_pkg::mem_cmd_t mem_cmd;

    // load path
    logic [31:0] mem_rdata;
    logic [31:0] ld_rdata;

    // aligner already zeroes store responses
    assign rsp.rdata = ld_rdata;

    lsu_ctrl_fsm u_ctrl (
        .clock      (clock),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .timer_start(timer_start),
        .timer_done (timer_done),
        .held_req   (held_req),
        .st_wdata   (st_wdata),
        .st_wmask   (st_wmask),
        .mem_cmd    (mem_cmd)
    );

    // wait states of the slow memory
    lsu_wait_timer u_timer (
        .clock (clock),
        .arst_n(arst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    lsu_store_align u_st_align (
        .op      (held_req.op),
        .offset  (held_req.addr[1:0]),
        .wdata   (held_req.wdata),
        .st_wdata(st_wdata),
        .st_wmask(st_wmask)
    );

    lsu_data_sram u_sram (
        .clock  (clock),
        .mem_cmd(mem_cmd),
        .rdata  (mem_rdata)
    );

    lsu_load_align u_ld_align (
        .op      (held_req.op),
        .offset  (held_req.addr[1:0]),
        .mem_word(mem_rdata),
        .rdata   (ld_rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/lsu_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_wait_timer (
    input  wire logic clock,
    input  wire logic arst_n,
    input  wire logic start,
    output logic      done
);

    logic [lsu_pkg::LAT_W-1:0] count;
    logic                      busy;

    // done only for a loaded counter that has run down
    assign done = busy && (count == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (start) begin
            count <= lsu_pkg::LAT_W'(lsu_pkg::MEM_LATENCY);
            busy  <= 1'b1;
        end else if (busy) begin
            if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                // back to idle after the done cycle
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/lsu_pkg.sv
hdl/lsu_wait_timer.sv
hdl/lsu_store_align.sv
hdl/lsu_load_align.sv
hdl/lsu_data_sram.sv
hdl/lsu_ctrl_fsm.sv
hdl/lsu_top.sv
tests/lsu_props.sv
tests/lsu_tb.sv

// ==== tests/lsu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_props (
    input wire logic              clock,
    input wire logic              arst_n,
    input wire logic              req_valid,
    input wire logic              req_ready,
    input wire logic              rsp_valid,
    input wire lsu_pkg::lsu_rsp_t rsp,
    input wire logic              rsp_ready,
    input wire lsu_pkg::mem_cmd_t mem_cmd
);

    // response held under back-pressure
    assert property (@(posedge clock) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("rsp changed or dropped while stalled");

    // never idle and answering at once
    assert property (@(posedge clock) disable iff (!arst_n)
        !(req_ready && rsp_valid))
        else $error("req_ready and rsp_valid high together");

    // lanes only on a write
    assert property (@(posedge clock) disable iff (!arst_n)
        (mem_cmd.wmask != 4'b0000) |-> mem_cmd.we)
        else $error("wmask set without we");

    // wait states, access cycle, then the response
    assert property (@(posedge clock) disable iff (!arst_n)
        (req_valid && req_ready) |-> ##(lsu_pkg::MEM_LATENCY + 3) $rose(rsp_valid))
        else $error("rsp_valid not raised on time after accept");

endmodule

bind lsu_top lsu_props u_props (
    .clock    (clock),
    .arst_n   (arst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .rsp      (rsp),
    .rsp_ready(rsp_ready),
    .mem_cmd  (mem_cmd)
);

`default_nettype wire

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int CLK_PERIOD = 40;
    localparam logic [31:0] SEED = 32'hb3f6836a;
    // longest random rsp_ready stall in cycles
    localparam int MAX_STALL = 6;
    localparam int N_BP = 20;
    localparam int N_RANDOM = 300;
    localparam int TOTAL_REQS = 16 + 18 + 10 + 6 + N_BP + N_RANDOM;
    localparam int WATCHDOG_CYCLES =
        TOTAL_REQS * (lsu_pkg::MEM_LATENCY + 3 + MAX_STALL) + 500;

    logic clock;
    logic arst_n;
    logic req_valid;
    lsu_pkg::lsu_req_t req;
    logic req_ready;
    logic rsp_valid;
    lsu_pkg::lsu_rsp_t rsp;
    logic rsp_ready;

    // word indexed reference memory
    logic [31:0] ref_mem [lsu_pkg::MEM_WORDS];

    // expected rdata and accept edge per request in flight
    logic [31:0] exp_q [$];
    int unsigned acc_q [$];

    int unsigned edge_cnt;
    int n_checks;
    int n_errors;
    int n_reqs;
    int test_err_base;

    // rsp_ready back-pressure control
    logic bp_on;
    int stall_left;

    // compare process state
    logic rsp_valid_q;
    logic hold_pending;
    logic [31:0] held_rdata;

    lsu_top dut0 (
        .clock    (clock),
        .arst_n   (arst_n),
        .req_valid(req_valid),
        .req      (req),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp      (rsp),
        .rsp_ready(rsp_ready)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    always @(posedge clock) begin
        edge_cnt <= edge_cnt + 1;
    end

    // expected load result
    // stores update ref_mem and answer zero
    function automatic logic [31:0] ref_access(input lsu_pkg::lsu_op_e op,
                                               input logic [31:0] addr,
                                               input logic [31:0] wdata);
        logic [7:0] idx;
        logic [1:0] off;
        logic [31:0] word;
        logic [31:0] result;
        idx = addr[9:2];
        off = addr[1:0];
        word = ref_mem[idx];
        result = 32'h0;
        case (op)
            lsu_pkg::OP_LW: result = word;
            lsu_pkg::OP_LBU: result = {24'h0, word[off*8 +: 8]};
            lsu_pkg::OP_SW: ref_mem[idx] = wdata;
            default: begin
                // sb merges the low byte into one lane
                word[off*8 +: 8] = wdata[7:0];
                ref_mem[idx] = word;
            end
        endcase
        return result;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    // entered 2 ns after an edge
    // returns 2 ns after the accepting edge
    task automatic send_req(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        logic accepted;
        accepted = 1'b0;
        req_valid = 1'b1;
        req.op = op;
        req.addr = addr;
        req.wdata = wdata;
        while (!accepted) begin
            // req_ready only moves on edges
            accepted = req_ready;
            @(posedge clock);
            #2;
        end
        req_valid = 1'b0;
        exp_q.push_back(ref_access(op, addr, wdata));
        acc_q.push_back(edge_cnt);
        n_reqs++;
    endtask

    task automatic finish_test(input string name);
        int errs;
        // wait for all responses and then past the completing edge
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
        @(posedge clock);
        #2;
        errs = n_errors - test_err_base;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
        end
        test_err_base = n_errors;
    endtask

    // random low stretches on rsp_ready
    // at least one ready cycle between them
    always @(posedge clock) begin
        #2;
        if (stall_left > 0) begin
            rsp_ready = 1'b0;
            stall_left--;
        end else begin
            rsp_ready = 1'b1;
            if (bp_on && ($urandom % 3) == 0) begin
                stall_left = 1 + ($urandom % MAX_STALL);
            end
        end
    end

    // compare at mid-cycle where outputs are stable
    always @(negedge clock) begin
        if (arst_n) begin
            if (hold_pending) begin
                check("rsp_valid", rsp_valid, 1'b1);
                check("rsp.rdata", rsp.rdata, held_rdata);
            end
            if (rsp_valid && !rsp_valid_q) begin
                if (acc_q.size() == 0) begin
                    $display("error at %0t ns: response raised with no request accepted", $time);
                    n_errors++;
                end else begin
                    check("rsp_latency", edge_cnt - acc_q.pop_front(),
                          lsu_pkg::MEM_LATENCY + 2);
                end
            end
            // one request in flight
            if (exp_q.size() != 0) begin
                check("req_ready", req_ready, 1'b0);
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t ns: response taken with nothing expected", $time);
                    n_errors++;
                end else begin
                    check("rsp.rdata", rsp.rdata, exp_q.pop_front());
                end
            end
            hold_pending = rsp_valid && !rsp_ready;
            held_rdata = rsp.rdata;
            rsp_valid_q = rsp_valid;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0] written;
        int w;
        int pick;
        lsu_pkg::lsu_op_e op;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        arst_n = 1'b0;
        bp_on = 1'b0;
        stall_left = 0;
        edge_cnt = 0;
        n_checks = 0;
        n_errors = 0;
        n_reqs = 0;
        test_err_base = 0;
        rsp_valid_q = 1'b0;
        hold_pending = 1'b0;
        held_rdata = 32'h0;
        written = 8'h0;
        void'($urandom(SEED));
        repeat (2) @(posedge clock);
        #2;
        arst_n = 1'b1;

        // word stores then loads with differing low address bits
        for (int i = 0; i < 8; i++) begin
            send_req(lsu_pkg::OP_SW, 32'h40 + i * 4 + (i % 4), $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            send_req(lsu_pkg::OP_LW, 32'h40 + i * 4 + (3 - i % 4), 32'h0);
        end
        finish_test("word_round_trip");

        // each sb read back at once so the untouched lanes show
        for (int i = 0; i < 2; i++) begin
            addr = 32'h80 + i * 4;
            send_req(lsu_pkg::OP_SW, addr, $urandom);
            for (int off = 0; off < 4; off++) begin
                send_req(lsu_pkg::OP_SB, addr + off, $urandom);
                send_req(lsu_pkg::OP_LW, addr, 32'h0);
            end
        end
        finish_test("byte_stores");

        for (int i = 0; i < 2; i++) begin
            addr = 32'hc0 + i * 4;
            send_req(lsu_pkg::OP_SW, addr, $urandom);
            for (int off = 0; off < 4; off++) begin
                send_req(lsu_pkg::OP_LBU, addr + off, 32'h0);
            end
        end
        finish_test("byte_loads");

        // latency checked in the compare process for every request
        for (int i = 0; i < 3; i++) begin
            send_req(lsu_pkg::OP_SW, 32'h100 + i * 4, $urandom);
            send_req(lsu_pkg::OP_LW, 32'h100 + i * 4, 32'h0);
        end
        finish_test("latency");

        bp_on = 1'b1;
        for (int i = 0; i < N_BP / 2; i++) begin
            word = $urandom;
            send_req(lsu_pkg::OP_SW, 32'h140 + (i % 4) * 4, word);
            send_req(lsu_pkg::OP_LW, 32'h140 + (i % 4) * 4, 32'h0);
        end
        finish_test("back_pressure");

        // small window with loads only on words a sw has filled
        for (int n = 0; n < N_RANDOM; n++) begin
            w = $urandom % 8;
            pick = $urandom % 4;
            addr = 32'h200 + w * 4 + ($urandom % 4);
            if (!written[w] && pick < 2) begin
                pick = 2;
            end
            case (pick)
                0: op = lsu_pkg::OP_LW;
                1: op = lsu_pkg::OP_LBU;
                2: op = lsu_pkg::OP_SW;
                default: op = lsu_pkg::OP_SB;
            endcase
            if (op == lsu_pkg::OP_SW) begin
                written[w] = 1'b1;
            end
            send_req(op, addr, $urandom);
        end
        finish_test("random_mix");

        $display("done: %0d requests, %0d checks, %0d errors", n_reqs, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
